//--- verilog/iir_biquad_pkg.sv
// Filter data types and Q2.14 coefficient constants
// Frequency is a normalized index k, with w0 = pi*k/64

package iir_biquad_pkg;

    localparam int SAMPLE_WIDTH   = 16;
    localparam int COEF_WIDTH     = 16;
    localparam int ACC_WIDTH      = 36;
    localparam int FREQ_IDX_WIDTH = 6;
    // Wide signed format for intermediate terms in the calculator
    localparam int CALC_WIDTH     = 18;
    localparam int COEF_FRAC      = 14;
    localparam int COEF_ONE       = 1 << COEF_FRAC;
    localparam int SAMPLE_MAX     = (1 << (SAMPLE_WIDTH - 1)) - 1;
    localparam int SAMPLE_MIN     = -(1 << (SAMPLE_WIDTH - 1));

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic signed [COEF_WIDTH-1:0]   coef_t;
    typedef logic signed [ACC_WIDTH-1:0]    acc_t;
    typedef logic signed [CALC_WIDTH-1:0]   calc_t;
    typedef logic [FREQ_IDX_WIDTH-1:0]      freq_idx_t;

    typedef enum logic [1:0] {
        LOWPASS  = 2'd0,
        HIGHPASS = 2'd1
    } filt_type_e;

    // Quarter wave sine in Q2.14, entry i is sin(pi*i/64)
    localparam coef_t SIN_TABLE [0:32] = '{
        16'sd0,     16'sd804,   16'sd1606,  16'sd2404,  16'sd3196,  16'sd3981,
        16'sd4756,  16'sd5520,  16'sd6270,  16'sd7005,  16'sd7723,  16'sd8423,
        16'sd9102,  16'sd9760,  16'sd10394, 16'sd11003, 16'sd11585, 16'sd12140,
        16'sd12665, 16'sd13160, 16'sd13623, 16'sd14053, 16'sd14449, 16'sd14811,
        16'sd15137, 16'sd15426, 16'sd15679, 16'sd15893, 16'sd16069, 16'sd16207,
        16'sd16305, 16'sd16364, 16'sd16384
    };

endpackage

//--- verilog/iir_biquad_apb_addr_pkg.sv
// APB bus widths and register map, base address fixed at zero

package iir_biquad_apb_addr_pkg;

    localparam int APB_ADDR_WIDTH = 8;
    localparam int APB_DATA_WIDTH = 32;

    typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

    // ----------------------------------------
    // Configuration registers, read and write
    // ----------------------------------------
    localparam apb_addr_t CR_IIR_F0_ADDR_C     = 8'h00;
    localparam apb_addr_t CR_IIR_Q_ADDR_C      = 8'h04;
    localparam apb_addr_t CR_IIR_TYPE_ADDR_C   = 8'h08;
    localparam apb_addr_t CR_IIR_BYPASS_ADDR_C = 8'h0C;

    // ----------------------------------------
    // Status registers, read only
    // ----------------------------------------
    // Normalized zeros
    localparam apb_addr_t SR_ZERO_B0_ADDR_C    = 8'h10;
    localparam apb_addr_t SR_ZERO_B1_ADDR_C    = 8'h14;
    localparam apb_addr_t SR_ZERO_B2_ADDR_C    = 8'h18;
    // Normalized poles
    localparam apb_addr_t SR_POLE_A1_ADDR_C    = 8'h1C;
    localparam apb_addr_t SR_POLE_A2_ADDR_C    = 8'h20;

endpackage

//--- verilog/iir_biquad_apb_slave.sv
// APB3 slave with one wait state per transfer
// Unmapped reads return zero, unmapped writes are dropped

module iir_biquad_apb_slave
    import iir_biquad_pkg::*;
    import iir_biquad_apb_addr_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // APB3 port
    input  apb_addr_t  paddr,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_data_t  pwdata,
    output logic       pready,
    output apb_data_t  prdata,

    // Configuration towards calculator and core
    output freq_idx_t  cr_iir_f0,
    output coef_t      cr_iir_q,
    output filt_type_e cr_iir_type,
    output logic       cr_bypass,
    output logic       cfg_update,

    // Coefficient status from calculator
    input  coef_t      sr_zero_b0,
    input  coef_t      sr_zero_b1,
    input  coef_t      sr_zero_b2,
    input  coef_t      sr_pole_a1,
    input  coef_t      sr_pole_a2
);

    logic      access;
    logic      wr_done;
    apb_data_t rd_data;

    // Sign extension of a coefficient onto the bus
    function automatic apb_data_t sext_coef(input coef_t c);
        return {{(APB_DATA_WIDTH - COEF_WIDTH){c[COEF_WIDTH-1]}}, c};
    endfunction

    // Access phase, transfer ends when pready is seen high
    assign access  = psel && penable;
    assign wr_done = access && pready && pwrite;

    // ----------------------------------------
    // Read mux
    // ----------------------------------------
    always_comb begin
        case (paddr)
            CR_IIR_F0_ADDR_C:     rd_data = apb_data_t'(cr_iir_f0);
            CR_IIR_Q_ADDR_C:      rd_data = sext_coef(cr_iir_q);
            CR_IIR_TYPE_ADDR_C:   rd_data = apb_data_t'(cr_iir_type);
            CR_IIR_BYPASS_ADDR_C: rd_data = apb_data_t'(cr_bypass);
            SR_ZERO_B0_ADDR_C:    rd_data = sext_coef(sr_zero_b0);
            SR_ZERO_B1_ADDR_C:    rd_data = sext_coef(sr_zero_b1);
            SR_ZERO_B2_ADDR_C:    rd_data = sext_coef(sr_zero_b2);
            SR_POLE_A1_ADDR_C:    rd_data = sext_coef(sr_pole_a1);
            SR_POLE_A2_ADDR_C:    rd_data = sext_coef(sr_pole_a2);
            default:              rd_data = '0;
        endcase
    end

    // ----------------------------------------
    // Handshake and register writes
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pready      <= 1'b0;
            prdata      <= '0;
            cfg_update  <= 1'b0;
            cr_iir_f0   <= '0;
            cr_iir_q    <= '0;
            cr_iir_type <= LOWPASS;
            cr_bypass   <= 1'b0;
        end else begin
            // One cycle high, then low again after the completing edge
            pready     <= access && !pready;
            prdata     <= '0;
            cfg_update <= 1'b0;

            // Read data registered together with pready
            if (access && !pready && !pwrite) begin
                prdata <= rd_data;
            end

            if (wr_done) begin
                case (paddr)
                    CR_IIR_F0_ADDR_C: begin
                        cr_iir_f0  <= pwdata[FREQ_IDX_WIDTH-1:0];
                        cfg_update <= 1'b1;
                    end
                    CR_IIR_Q_ADDR_C: begin
                        cr_iir_q   <= pwdata[COEF_WIDTH-1:0];
                        cfg_update <= 1'b1;
                    end
                    CR_IIR_TYPE_ADDR_C: begin
                        // Unknown types fall back to lowpass
                        cr_iir_type <= (pwdata[1:0] == HIGHPASS) ? HIGHPASS : LOWPASS;
                        cfg_update  <= 1'b1;
                    end
                    // Bypass does not need new coefficients
                    CR_IIR_BYPASS_ADDR_C: cr_bypass <= pwdata[0];
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- verilog/iir_coef_calc.sv
// Biquad coefficient calculator, 24 cycles from start to coef_valid
// Assumes q_recip >= 0, so that a0 = 1 + alpha stays at or above one

module iir_coef_calc
    import iir_biquad_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  freq_idx_t  f0_idx,
    input  coef_t      q_recip,
    input  filt_type_e filt_type,
    input  logic       start,
    output coef_t      b0,
    output coef_t      b1,
    output coef_t      b2,
    output coef_t      a1,
    output coef_t      a2,
    output logic       coef_valid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_DIVIDE,
        ST_SCALE
    } state_e;

    state_e      state;
    logic [4:0]  step;

    // Inputs captured on start
    freq_idx_t   f0_r;
    coef_t       q_r;
    filt_type_e  type_r;

    // Intermediate terms
    calc_t       sin_r;
    calc_t       cos_r;
    calc_t       alpha_r;
    logic [17:0] rem_r;
    logic [15:0] quo_r;
    coef_t       res_b0;
    coef_t       res_b1;
    coef_t       res_a1;
    coef_t       res_a2;

    freq_idx_t   sin_idx;
    freq_idx_t   cos_idx;
    logic        cos_neg;
    acc_t        alpha_prod;
    calc_t       a0;
    logic [17:0] rem_shift;
    calc_t       half_term;
    calc_t       raw;
    acc_t        scale_prod;

    // ----------------------------------------
    // Combinational datapath
    // ----------------------------------------
    always_comb begin
        // Fold 0..pi onto the quarter wave table
        if (f0_r <= 6'd32) begin
            sin_idx = f0_r;
            cos_idx = 6'd32 - f0_r;
            cos_neg = 1'b0;
        end else begin
            sin_idx = 6'(7'd64 - 7'(f0_r));
            cos_idx = f0_r - 6'd32;
            cos_neg = 1'b1;
        end
        alpha_prod = sin_r * q_r;
        a0         = calc_t'(COEF_ONE) + alpha_r;
        rem_shift  = {rem_r[16:0], 1'b0};
        // 1 - cos for lowpass, 1 + cos for highpass
        half_term  = (type_r == HIGHPASS) ? calc_t'(COEF_ONE) + cos_r
                                          : calc_t'(COEF_ONE) - cos_r;
        case (step)
            5'd0:    raw = half_term >>> 1;
            5'd1:    raw = (type_r == HIGHPASS) ? -half_term : half_term;
            5'd2:    raw = -(cos_r <<< 1);
            default: raw = calc_t'(COEF_ONE) - alpha_r;
        endcase
        // Normalize by 1/a0, arithmetic shift truncates toward minus infinity
        scale_prod = raw * calc_t'({2'b00, quo_r});
    end

    // ----------------------------------------
    // Sequencer and result registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            step       <= '0;
            coef_valid <= 1'b0;
            b0         <= '0;
            b1         <= '0;
            b2         <= '0;
            a1         <= '0;
            a2         <= '0;
        end else begin
            coef_valid <= 1'b0;
            step       <= step + 5'd1;
            if (start) begin
                // Restart from scratch, even mid calculation
                state <= ST_LOOKUP;
                step  <= '0;
            end else begin
                case (state)
                    ST_LOOKUP: if (step == 5'd1) begin
                        state <= ST_DIVIDE;
                        step  <= '0;
                    end
                    ST_DIVIDE: if (step == 5'd15) begin
                        state <= ST_SCALE;
                        step  <= '0;
                    end
                    ST_SCALE: if (step == 5'd4) begin
                        // All five coefficients change together
                        state      <= ST_IDLE;
                        coef_valid <= 1'b1;
                        b0         <= res_b0;
                        b1         <= res_b1;
                        b2         <= res_b0;
                        a1         <= res_a1;
                        a2         <= res_a2;
                    end
                    default: step <= '0;
                endcase
            end
        end
    end

    // ----------------------------------------
    // Working registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (start) begin
            f0_r   <= f0_idx;
            q_r    <= q_recip;
            type_r <= filt_type;
        end
        if (state == ST_LOOKUP && step == 5'd0) begin
            sin_r <= calc_t'(SIN_TABLE[sin_idx]);
            cos_r <= cos_neg ? -calc_t'(SIN_TABLE[cos_idx]) : calc_t'(SIN_TABLE[cos_idx]);
        end
        if (state == ST_LOOKUP && step == 5'd1) begin
            alpha_r <= calc_t'(alpha_prod >>> COEF_FRAC);
            // 2^28 / a0, first partial remainder is 2^28 >> 16
            rem_r   <= 18'd4096;
            quo_r   <= '0;
        end
        // Restoring division, one quotient bit per cycle
        if (state == ST_DIVIDE) begin
            if (rem_shift >= $unsigned(a0)) begin
                rem_r <= rem_shift - $unsigned(a0);
                quo_r <= {quo_r[14:0], 1'b1};
            end else begin
                rem_r <= rem_shift;
                quo_r <= {quo_r[14:0], 1'b0};
            end
        end
        if (state == ST_SCALE) begin
            case (step)
                5'd0:    res_b0 <= coef_t'(scale_prod >>> COEF_FRAC);
                5'd1:    res_b1 <= coef_t'(scale_prod >>> COEF_FRAC);
                5'd2:    res_a1 <= coef_t'(scale_prod >>> COEF_FRAC);
                5'd3:    res_a2 <= coef_t'(scale_prod >>> COEF_FRAC);
                default: ;
            endcase
        end
    end

endmodule

//--- verilog/iir_biquad_core.sv
// Direct Form I biquad, one output per input strobe, 1 cycle later
// New coefficients clear the delay line

module iir_biquad_core
    import iir_biquad_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  coef_t   b0,
    input  coef_t   b1,
    input  coef_t   b2,
    input  coef_t   a1,
    input  coef_t   a2,
    input  logic    coef_valid,
    input  logic    bypass,
    input  sample_t sample_in,
    input  logic    sample_in_valid,
    output sample_t sample_out,
    output logic    sample_out_valid
);

    // Active coefficient set
    coef_t   b0_r;
    coef_t   b1_r;
    coef_t   b2_r;
    coef_t   a1_r;
    coef_t   a2_r;

    // Delay line
    sample_t x1;
    sample_t x2;
    sample_t y1;
    sample_t y2;

    acc_t    acc;
    acc_t    acc_shift;
    sample_t y_sat;

    // ----------------------------------------
    // Multiply accumulate and saturation
    // ----------------------------------------
    always_comb begin
        acc       = b0_r * sample_in + b1_r * x1 + b2_r * x2 - a1_r * y1 - a2_r * y2;
        acc_shift = acc >>> COEF_FRAC;
        if (acc_shift > SAMPLE_MAX) begin
            y_sat = sample_t'(SAMPLE_MAX);
        end else if (acc_shift < SAMPLE_MIN) begin
            y_sat = sample_t'(SAMPLE_MIN);
        end else begin
            y_sat = acc_shift[SAMPLE_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b0_r             <= '0;
            b1_r             <= '0;
            b2_r             <= '0;
            a1_r             <= '0;
            a2_r             <= '0;
            x1               <= '0;
            x2               <= '0;
            y1               <= '0;
            y2               <= '0;
            sample_out       <= '0;
            sample_out_valid <= 1'b0;
        end else begin
            sample_out_valid <= sample_in_valid;
            if (sample_in_valid) begin
                // Bypass only changes the output, the filter keeps running
                sample_out <= bypass ? sample_in : y_sat;
                x1         <= sample_in;
                x2         <= x1;
                y1         <= y_sat;
                y2         <= y1;
            end
            // Coefficient change wins over a sample in the same cycle
            if (coef_valid) begin
                b0_r <= b0;
                b1_r <= b1;
                b2_r <= b2;
                a1_r <= a1;
                a2_r <= a2;
                x1   <= '0;
                x2   <= '0;
                y1   <= '0;
                y2   <= '0;
            end
        end
    end

endmodule

//--- verilog/iir_biquad_top.sv
// Biquad filter with APB3 control, base address zero
// Coefficients follow 25 cycles after a configuration write

module iir_biquad_top
    import iir_biquad_pkg::*;
    import iir_biquad_apb_addr_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // APB3 port
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_data_t pwdata,
    output logic      pready,
    output apb_data_t prdata,

    // Sample stream
    input  sample_t   sample_in,
    input  logic      sample_in_valid,
    output sample_t   sample_out,
    output logic      sample_out_valid
);

    // Configuration
    freq_idx_t  cr_iir_f0;
    coef_t      cr_iir_q;
    filt_type_e cr_iir_type;
    logic       cr_bypass;
    logic       cfg_update;

    // Calculated coefficients
    coef_t      b0;
    coef_t      b1;
    coef_t      b2;
    coef_t      a1;
    coef_t      a2;
    logic       coef_valid;

    iir_biquad_apb_slave iir_biquad_apb_slave_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .pready      (pready),
        .prdata      (prdata),
        .cr_iir_f0   (cr_iir_f0),
        .cr_iir_q    (cr_iir_q),
        .cr_iir_type (cr_iir_type),
        .cr_bypass   (cr_bypass),
        .cfg_update  (cfg_update),
        .sr_zero_b0  (b0),
        .sr_zero_b1  (b1),
        .sr_zero_b2  (b2),
        .sr_pole_a1  (a1),
        .sr_pole_a2  (a2)
    );

    iir_coef_calc iir_coef_calc_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .f0_idx     (cr_iir_f0),
        .q_recip    (cr_iir_q),
        .filt_type  (cr_iir_type),
        .start      (cfg_update),
        .b0         (b0),
        .b1         (b1),
        .b2         (b2),
        .a1         (a1),
        .a2         (a2),
        .coef_valid (coef_valid)
    );

    iir_biquad_core iir_biquad_core_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .b0               (b0),
        .b1               (b1),
        .b2               (b2),
        .a1               (a1),
        .a2               (a2),
        .coef_valid       (coef_valid),
        .bypass           (cr_bypass),
        .sample_in        (sample_in),
        .sample_in_valid  (sample_in_valid),
        .sample_out       (sample_out),
        .sample_out_valid (sample_out_valid)
    );

endmodule

//--- tests/iir_biquad_checker.sv
// Result checker, compares DUT responses with values queued by the driver
// Sampled on the falling edge where read data and samples are stable

module iir_biquad_checker
    import iir_biquad_pkg::*;
    import iir_biquad_apb_addr_pkg::*;
(
    input logic      clk,
    input logic      psel,
    input logic      penable,
    input logic      pready,
    input logic      pwrite,
    input apb_data_t prdata,
    input logic      sample_in_valid,
    input sample_t   sample_out,
    input logic      sample_out_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    string     test_name = "none";
    apb_data_t read_queue[$];
    sample_t   sample_queue[$];
    apb_data_t read_exp;
    sample_t   sample_exp;
    int        test_errors = 0;
    int        tests_passed = 0;
    int        tests_failed = 0;
    int        total_errors = 0;
    int        access_cycles = 0;
    logic      pready_exp;
    logic      in_valid_d = 1'b0;

    task automatic begin_test(input string name);
        test_name = name;
    endtask

    task automatic expect_read(input apb_data_t value);
        read_queue.push_back(value);
    endtask

    task automatic expect_sample(input sample_t value);
        sample_queue.push_back(value);
    endtask

    function automatic int pending();
        return read_queue.size() + sample_queue.size();
    endfunction

    function automatic bit all_passed();
        return tests_passed > 0 && tests_failed == 0 && test_errors == 0 && pending() == 0;
    endfunction

    // ----------------------------------------
    // Per test verdict
    // ----------------------------------------
    task automatic end_test();
        if (read_queue.size() != 0) begin
            $display("%s: %0d expected read results never arrived", test_name, read_queue.size());
            test_errors += read_queue.size();
            read_queue.delete();
        end
        if (sample_queue.size() != 0) begin
            $display("%s: %0d expected output samples never arrived", test_name,
                     sample_queue.size());
            test_errors += sample_queue.size();
            sample_queue.delete();
        end
        total_errors += test_errors;
        if (test_errors == 0) begin
            tests_passed++;
            $display("ok   %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", test_name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic report_counts();
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, total_errors);
    endtask

    // ----------------------------------------
    // Compare on the falling edge
    // ----------------------------------------
    always @(negedge clk) begin
        // One wait state, pready only in the second access cycle
        if (psel && penable) begin
            access_cycles++;
        end else begin
            access_cycles = 0;
        end
        pready_exp = (access_cycles == 2);
        if (pready !== pready_exp) begin
            $display("** Error %s: pready expected %0b, actual %0b",
                     test_name, pready_exp, pready);
            test_errors++;
        end
        // Read data is valid while pready is high
        if (pready && !pwrite) begin
            if (read_queue.size() == 0) begin
                $display("%s: read data returned with no read outstanding", test_name);
                test_errors++;
            end else begin
                read_exp = read_queue.pop_front();
                if (prdata !== read_exp) begin
                    $display("** Error %s: prdata expected 0x%08h, actual 0x%08h",
                             test_name, read_exp, prdata);
                    test_errors++;
                end
            end
        end
        // Output strobe follows the input strobe by exactly 1 cycle
        if (sample_out_valid !== in_valid_d) begin
            $display("** Error %s: sample_out_valid expected %0b, actual %0b",
                     test_name, in_valid_d, sample_out_valid);
            test_errors++;
        end
        in_valid_d = sample_in_valid;
        if (sample_out_valid) begin
            if (sample_queue.size() == 0) begin
                $display("%s: output sample with no input outstanding", test_name);
                test_errors++;
            end else begin
                sample_exp = sample_queue.pop_front();
                if (sample_out !== sample_exp) begin
                    $display("** Error %s: sample_out expected %0d, actual %0d",
                             test_name, sample_exp, sample_out);
                    test_errors++;
                end
            end
        end
    end

endmodule

//--- tests/tb_iir_biquad_top.sv
// Trace driven testbench, must be run from the project root
// One trace command at a time, inputs change just after the rising edge

module tb_iir_biquad_top
    import iir_biquad_pkg::*;
    import iir_biquad_apb_addr_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam string TRACE_FILE = "tests/iir_biquad_trace.txt";

    logic      clk;
    logic      rst_n;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    logic      pready;
    apb_data_t prdata;
    sample_t   sample_in;
    logic      sample_in_valid;
    sample_t   sample_out;
    logic      sample_out_valid;

    int        cycle_count = 0;
    int        cycle_limit = 0;

    iir_biquad_top iir_biquad_top_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .paddr            (paddr),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .pwdata           (pwdata),
        .pready           (pready),
        .prdata           (prdata),
        .sample_in        (sample_in),
        .sample_in_valid  (sample_in_valid),
        .sample_out       (sample_out),
        .sample_out_valid (sample_out_valid)
    );

    iir_biquad_checker iir_biquad_checker_i (
        .clk              (clk),
        .psel             (psel),
        .penable          (penable),
        .pready           (pready),
        .pwrite           (pwrite),
        .prdata           (prdata),
        .sample_in_valid  (sample_in_valid),
        .sample_out       (sample_out),
        .sample_out_valid (sample_out_valid)
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog on total run length
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the trace did not complete", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Drivers
    // ----------------------------------------
    // Every edge drops the sample strobe unless a sample is driven again
    task automatic next_edge();
        @(posedge clk);
        sample_in_valid <= 1'b0;
    endtask

    task automatic apb_transfer(input apb_addr_t addr, input logic write, input apb_data_t data);
        // Setup phase
        next_edge();
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= data;
        psel    <= 1'b1;
        penable <= 1'b0;
        // Access phase until pready
        next_edge();
        penable <= 1'b1;
        do begin
            @(negedge clk);
        end while (!pready);
        // Completing edge
        next_edge();
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic send_sample(input sample_t value, input sample_t expected);
        iir_biquad_checker_i.expect_sample(expected);
        next_edge();
        sample_in       <= value;
        sample_in_valid <= 1'b1;
    endtask

    // Output arrives 1 cycle after its strobe, so a few edges drain it
    task automatic finish_test();
        int spins;
        spins = 0;
        while (iir_biquad_checker_i.pending() != 0 && spins < 4) begin
            next_edge();
            spins++;
        end
        iir_biquad_checker_i.end_test();
    endtask

    // ----------------------------------------
    // Trace reader
    // ----------------------------------------
    initial begin
        int        fd;
        int        lines;
        int        n;
        int        value_in;
        int        value_exp;
        bit        trace_ok;
        apb_addr_t addr;
        apb_data_t data;
        string     line;
        string     cmd;
        string     name;

        paddr           <= '0;
        psel            <= 1'b0;
        penable         <= 1'b0;
        pwrite          <= 1'b0;
        pwdata          <= '0;
        sample_in       <= '0;
        sample_in_valid <= 1'b0;
        rst_n           <= 1'b0;
        trace_ok = 1'b1;
        lines    = 0;

        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the trace file %s", TRACE_FILE);
            trace_ok = 1'b0;
        end else begin
            // Run length limit from the trace length
            while ($fgets(line, fd) != 0) begin
                lines++;
            end
            $fclose(fd);
            cycle_limit = 40 * lines + 200;

            repeat (16) @(posedge clk);
            rst_n <= 1'b1;

            fd = $fopen(TRACE_FILE, "r");
            while ($fgets(line, fd) != 0) begin
                cmd = "";
                n = $sscanf(line, "%s", cmd);
                // Blank and comment lines
                if (n < 1 || cmd.getc(0) == "#") begin
                    continue;
                end
                if (cmd == "test") begin
                    void'($sscanf(line, "%s %s", cmd, name));
                    iir_biquad_checker_i.begin_test(name);
                end else if (cmd == "wr") begin
                    void'($sscanf(line, "%s %h %h", cmd, addr, data));
                    apb_transfer(addr, 1'b1, data);
                end else if (cmd == "rd") begin
                    void'($sscanf(line, "%s %h %h", cmd, addr, data));
                    iir_biquad_checker_i.expect_read(data);
                    apb_transfer(addr, 1'b0, '0);
                end else if (cmd == "smp") begin
                    void'($sscanf(line, "%s %d %d", cmd, value_in, value_exp));
                    send_sample(sample_t'(value_in), sample_t'(value_exp));
                end else if (cmd == "wait") begin
                    void'($sscanf(line, "%s %d", cmd, value_in));
                    repeat (value_in) next_edge();
                end else if (cmd == "end") begin
                    finish_test();
                end else begin
                    $display("Unknown trace command %s", cmd);
                    trace_ok = 1'b0;
                end
            end
            $fclose(fd);
        end

        iir_biquad_checker_i.report_counts();
        if (trace_ok && iir_biquad_checker_i.all_passed()) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- iir_biquad_top.f
verilog/iir_biquad_pkg.sv
verilog/iir_biquad_apb_addr_pkg.sv
verilog/iir_biquad_apb_slave.sv
verilog/iir_coef_calc.sv
verilog/iir_biquad_core.sv
verilog/iir_biquad_top.sv
tests/iir_biquad_checker.sv
tests/tb_iir_biquad_top.sv

//--- Makefile
# Verilator build and run for the IIR biquad testbench
# Run from the project root, the trace path is relative to it

VERILATOR ?= verilator
TOP       ?= tb_iir_biquad_top
FILELIST  ?= iir_biquad_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= test passed

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/iir_biquad_trace.txt
# test <name> | wr <addr> <data> | rd <addr> <expected>, addresses and data in hex
# smp <input> <expected output> in signed decimal | wait <cycles> | end
test reset_state
rd 10 00000000
rd 14 00000000
rd 18 00000000
rd 1c 00000000
rd 20 00000000
smp 1000 0
smp -2000 0
smp 300 0
end
test register_access
wr 00 000000ff
rd 00 0000003f
wr 04 00001234
rd 04 00001234
wr 08 00000003
rd 08 00000000
wr 08 00000001
rd 08 00000001
wr 0c 00000001
rd 0c 00000001
wr 0c 00000000
rd 0c 00000000
rd 40 00000000
end
test lowpass
wr 00 00000010
wr 04 00002000
wr 08 00000000
wait 30
rd 10 000006ec
rd 14 00000dd9
rd 18 000006ec
rd 1c ffffbd22
rd 20 00001e91
end
test highpass_impulse
wr 08 00000001
wait 30
rd 10 0000285a
rd 14 ffffaf49
rd 18 0000285a
rd 1c ffffbd22
rd 20 00001e91
smp 16384 10330
smp 0 -9871
smp 0 -4917
smp 0 -423
end
test bypass
wr 0c 00000001
smp 1234 1234
smp -5678 -5678
smp 32767 32767
wr 0c 00000000
wr 08 00000001
wait 30
smp 16384 10330
smp 0 -9871
end
test back_to_back
wr 08 00000001
wait 30
smp 8192 5165
smp 0 -4936
smp 0 -2459
end
